// ==== design/decodePkg.sv ====
package decodePkg;

    //////////////////////////////
    // Field types
    //////////////////////////////
    typedef logic [4:0] opcodeT;   // instr[15:11]
    typedef logic [1:0] funcModeT; // instr[1:0], R-format mode
    typedef logic [3:0] aluOpT;    // ALU operation select
    typedef logic [2:0] extSelT;   // Immediate extension select
    typedef logic [1:0] regDstT;   // Write register select

    // Write register select
    localparam regDstT REG_DST_RS   = 2'd0; // instr[10:8]
    localparam regDstT REG_DST_RD_I = 2'd1; // instr[7:5]
    localparam regDstT REG_DST_RD_R = 2'd2; // instr[4:2]
    localparam regDstT REG_DST_R7   = 2'd3; // Link register

    //////////////////////////////
    // ALU operations
    //////////////////////////////
    localparam aluOpT ALU_ROL    = 4'd0;  // Shifter group, low bits pick the shift
    localparam aluOpT ALU_SLL    = 4'd1;
    localparam aluOpT ALU_ROR    = 4'd2;
    localparam aluOpT ALU_SRL    = 4'd3;
    localparam aluOpT ALU_ADD    = 4'd4;
    localparam aluOpT ALU_AND    = 4'd5;
    localparam aluOpT ALU_XOR    = 4'd7;
    localparam aluOpT ALU_BTR    = 4'd8;  // Bit reverse of A
    localparam aluOpT ALU_SEQ    = 4'd9;  // Set on A == B
    localparam aluOpT ALU_SLT    = 4'd10;
    localparam aluOpT ALU_SLE    = 4'd11;
    localparam aluOpT ALU_SCO    = 4'd12; // Set on carry out of A + B
    localparam aluOpT ALU_PASS_B = 4'd13;
    localparam aluOpT ALU_SLBI   = 4'd14; // (A << 8) | B
    localparam aluOpT ALU_PASS_A = 4'd15;

    // Immediate extension
    localparam extSelT EXT_SIGN5  = 3'd0;
    localparam extSelT EXT_SIGN8  = 3'd1;
    localparam extSelT EXT_SIGN11 = 3'd2;
    localparam extSelT EXT_ZERO5  = 3'd3;
    localparam extSelT EXT_ZERO8  = 3'd4;

    //////////////////////////////
    // Opcodes
    //////////////////////////////
    localparam opcodeT OP_HALT  = 5'b00000;
    localparam opcodeT OP_NOP   = 5'b00001;
    localparam opcodeT OP_SIIC  = 5'b00010;
    localparam opcodeT OP_RTI   = 5'b00011;
    localparam opcodeT OP_J     = 5'b00100;
    localparam opcodeT OP_JR    = 5'b00101;
    localparam opcodeT OP_JAL   = 5'b00110;
    localparam opcodeT OP_JALR  = 5'b00111;
    localparam opcodeT OP_ADDI  = 5'b01000;
    localparam opcodeT OP_SUBI  = 5'b01001;
    localparam opcodeT OP_XORI  = 5'b01010;
    localparam opcodeT OP_ANDNI = 5'b01011;
    localparam opcodeT OP_BEQZ  = 5'b01100;
    localparam opcodeT OP_BNEZ  = 5'b01101;
    localparam opcodeT OP_BLTZ  = 5'b01110;
    localparam opcodeT OP_BGEZ  = 5'b01111;
    localparam opcodeT OP_ST    = 5'b10000;
    localparam opcodeT OP_LD    = 5'b10001;
    localparam opcodeT OP_SLBI  = 5'b10010;
    localparam opcodeT OP_STU   = 5'b10011;
    localparam opcodeT OP_ROLI  = 5'b10100;
    localparam opcodeT OP_SLLI  = 5'b10101;
    localparam opcodeT OP_RORI  = 5'b10110;
    localparam opcodeT OP_SRLI  = 5'b10111;
    localparam opcodeT OP_LBI   = 5'b11000;
    localparam opcodeT OP_BTR   = 5'b11001;
    localparam opcodeT OP_SHIFT = 5'b11010; // ROL/SLL/ROR/SRL by funcMode
    localparam opcodeT OP_ARITH = 5'b11011; // ADD/SUB/XOR/ANDN by funcMode
    localparam opcodeT OP_SEQ   = 5'b11100;
    localparam opcodeT OP_SLT   = 5'b11101;
    localparam opcodeT OP_SLE   = 5'b11110;
    localparam opcodeT OP_SCO   = 5'b11111;

    // Full control word held by the decode stage
    // 16 single-bit controls plus the three vector fields
    localparam int CTRL_WORD_W = $bits(aluOpT) + $bits(extSelT) + $bits(regDstT) + 16;
    typedef logic [CTRL_WORD_W-1:0] ctrlWordT;

endpackage

// ==== design/aluControl.sv ====
`timescale 1ns/1ns

module aluControl (
    input  decodePkg::opcodeT   opcode,
    input  decodePkg::funcModeT funcMode,
    output decodePkg::aluOpT    aluOpNext,
    output logic                aluInvANext,
    output logic                aluInvBNext,
    output logic                aluCinNext,
    output logic                aluSrcNext,   // 1 selects immediate as B
    output decodePkg::extSelT   extSelectNext
);
    import decodePkg::*;

    always_comb begin
        // Everything off unless the opcode says otherwise
        aluOpNext     = '0;
        aluInvANext   = 1'b0;
        aluInvBNext   = 1'b0;
        aluCinNext    = 1'b0;
        aluSrcNext    = 1'b0;
        extSelectNext = '0;

        case (opcode)
            //////////////////////////////
            // I-format 1
            //////////////////////////////
            OP_ADDI: begin
                aluOpNext     = ALU_ADD;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_SIGN5;
            end
            OP_SUBI: begin                 // Rd = I - Rs
                aluOpNext     = ALU_ADD;
                aluInvANext   = 1'b1;
                aluCinNext    = 1'b1;      // Completes two's complement of Rs
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_SIGN5;
            end
            OP_XORI: begin
                aluOpNext     = ALU_XOR;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_ZERO5;
            end
            OP_ANDNI: begin                // Rs AND ~I
                aluOpNext     = ALU_AND;
                aluInvBNext   = 1'b1;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_ZERO5;
            end
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                // Opcode low bits line up with the shifter codes
                aluOpNext     = {2'b00, opcode[1:0]};
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_ZERO5; // Shift amount from low immediate bits
            end

            // Address is Rs + signed offset
            OP_ST, OP_LD, OP_STU: begin
                aluOpNext     = ALU_ADD;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_SIGN5;
            end

            //////////////////////////////
            // R-format
            //////////////////////////////
            OP_BTR:   aluOpNext = ALU_BTR;
            OP_SCO:   aluOpNext = ALU_SCO;
            OP_SHIFT: aluOpNext = {2'b00, funcMode};
            OP_ARITH: begin
                case (funcMode)
                    2'd0: aluOpNext = ALU_ADD;
                    2'd1: begin             // SUB, Rt - Rs
                        aluOpNext   = ALU_ADD;
                        aluInvANext = 1'b1;
                    end
                    2'd2: aluOpNext = ALU_XOR;
                    2'd3: begin             // ANDN
                        aluOpNext   = ALU_AND;
                        aluInvBNext = 1'b1;
                    end
                    default: aluOpNext = ALU_ADD;
                endcase
                aluCinNext = funcMode[0];   // Only SUB needs it, AND ignores carry
            end
            OP_SEQ, OP_SLT, OP_SLE: begin
                // Compare by A - B
                aluOpNext   = (opcode == OP_SEQ) ? ALU_SEQ :
                              (opcode == OP_SLT) ? ALU_SLT : ALU_SLE;
                aluInvBNext = 1'b1;
                aluCinNext  = 1'b1;
            end

            // Branch condition tests Rs directly
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                aluOpNext     = ALU_PASS_A;
                extSelectNext = EXT_SIGN8;
            end

            OP_LBI: begin
                aluOpNext     = ALU_PASS_B;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_SIGN8;
            end
            OP_SLBI: begin
                aluOpNext     = ALU_SLBI;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_ZERO8;
            end

            // PC-relative jumps, target built outside the ALU
            OP_J, OP_JAL:  extSelectNext = EXT_SIGN11;
            OP_JR, OP_JALR: begin           // Target is Rs + imm
                aluOpNext     = ALU_ADD;
                aluSrcNext    = 1'b1;
                extSelectNext = EXT_SIGN8;
            end

            default: ;                      // HALT, NOP, SIIC, RTI leave ALU idle
        endcase
    end

endmodule

// ==== design/flowControl.sv ====
`timescale 1ns/1ns

module flowControl (
    input  decodePkg::opcodeT opcode,
    output decodePkg::regDstT regDstNext,
    output logic              jumpNext,
    output logic              branchNext,
    output logic              memReadNext,
    output logic              memWriteNext,
    output logic              memToRegNext,  // Writeback from data memory
    output logic              regWriteNext,
    output logic              regToPcNext,   // PC loaded from ALU result
    output logic              pcToRegNext,   // PC + 2 written back
    output logic              haltNext,
    output logic              errNext,       // Illegal opcode
    output logic              rFormatNext,
    output logic              iFormatNext
);
    import decodePkg::*;

    always_comb begin
        regDstNext   = REG_DST_RS;
        jumpNext     = 1'b0;
        branchNext   = 1'b0;
        memReadNext  = 1'b0;
        memWriteNext = 1'b0;
        memToRegNext = 1'b0;
        regWriteNext = 1'b0;
        regToPcNext  = 1'b0;
        pcToRegNext  = 1'b0;
        haltNext     = 1'b0;
        errNext      = 1'b0;
        rFormatNext  = 1'b0;
        iFormatNext  = 1'b0;

        case (opcode)
            OP_HALT: haltNext = 1'b1;

            // Legal, no side effects
            OP_NOP, OP_SIIC, OP_RTI: ;

            //////////////////////////////
            // I-format 1
            //////////////////////////////
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                regDstNext   = REG_DST_RD_I;   // Rd in instr[7:5]
                regWriteNext = 1'b1;
                iFormatNext  = 1'b1;
            end

            OP_ST: begin                       // No writeback
                memWriteNext = 1'b1;
                iFormatNext  = 1'b1;
            end
            OP_LD: begin
                regDstNext   = REG_DST_RD_I;
                memReadNext  = 1'b1;
                memToRegNext = 1'b1;
                regWriteNext = 1'b1;
                iFormatNext  = 1'b1;
            end
            OP_STU: begin                      // Store, then Rs gets the address
                regDstNext   = REG_DST_RS;
                memWriteNext = 1'b1;
                regWriteNext = 1'b1;
                iFormatNext  = 1'b1;
            end

            //////////////////////////////
            // R-format
            //////////////////////////////
            OP_BTR, OP_SHIFT, OP_ARITH,
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                regDstNext   = REG_DST_RD_R;   // Rd in instr[4:2]
                regWriteNext = 1'b1;
                rFormatNext  = 1'b1;
            end

            // Condition resolved later on Rs
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: branchNext = 1'b1;

            OP_LBI, OP_SLBI: begin
                regDstNext   = REG_DST_RS;     // Immediate loads target Rs
                regWriteNext = 1'b1;
            end

            //////////////////////////////
            // Jumps
            //////////////////////////////
            OP_J:  jumpNext = 1'b1;
            OP_JR: begin
                jumpNext    = 1'b1;
                regToPcNext = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                regDstNext   = REG_DST_R7;     // Link into R7
                regWriteNext = 1'b1;
                pcToRegNext  = 1'b1;
                jumpNext     = 1'b1;
                regToPcNext  = (opcode == OP_JALR);
            end

            default: errNext = 1'b1;           // Unknown opcode, nothing else set
        endcase
    end

endmodule

// ==== design/controlStage.sv ====
`timescale 1ns/1ns

module controlStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    // ALU half
    input  decodePkg::aluOpT   aluOpNext,
    input  logic               aluInvANext,
    input  logic               aluInvBNext,
    input  logic               aluCinNext,
    input  logic               aluSrcNext,
    input  decodePkg::extSelT  extSelectNext,
    // Flow half
    input  decodePkg::regDstT  regDstNext,
    input  logic               jumpNext,
    input  logic               branchNext,
    input  logic               memReadNext,
    input  logic               memWriteNext,
    input  logic               memToRegNext,
    input  logic               regWriteNext,
    input  logic               regToPcNext,
    input  logic               pcToRegNext,
    input  logic               haltNext,
    input  logic               errNext,
    input  logic               rFormatNext,
    input  logic               iFormatNext,
    // Registered control word
    output decodePkg::aluOpT   aluOp,
    output logic               aluInvA,
    output logic               aluInvB,
    output logic               aluCin,
    output logic               aluSrc,
    output decodePkg::extSelT  extSelect,
    output decodePkg::regDstT  regDst,
    output logic               jump,
    output logic               branch,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               regWrite,
    output logic               regToPc,
    output logic               pcToReg,
    output logic               halt,
    output logic               err,
    output logic               rFormat,
    output logic               iFormat
);
    import decodePkg::*;

    ctrlWordT ctrlNext; // Merged decoder output
    ctrlWordT ctrlQ;    // Decode/execute register

    assign ctrlNext = {aluOpNext, aluInvANext, aluInvBNext, aluCinNext, aluSrcNext,
                       extSelectNext, regDstNext, jumpNext, branchNext, memReadNext,
                       memWriteNext, memToRegNext, regWriteNext, regToPcNext,
                       pcToRegNext, haltNext, errNext, rFormatNext, iFormatNext};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end else if (instrValid) begin
            ctrlQ <= ctrlNext;
        end else begin
            ctrlQ <= '0;          // Bubble, no enables reach execute
        end
    end

    // Same field order as ctrlNext
    assign {aluOp, aluInvA, aluInvB, aluCin, aluSrc, extSelect, regDst, jump, branch,
            memRead, memWrite, memToReg, regWrite, regToPc, pcToReg, halt, err,
            rFormat, iFormat} = ctrlQ;

endmodule

// ==== design/decodeTop.sv ====
`timescale 1ns/1ns

module decodeTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  decodePkg::opcodeT   opcode,
    input  decodePkg::funcModeT funcMode,
    output decodePkg::aluOpT    aluOp,
    output logic                aluInvA,
    output logic                aluInvB,
    output logic                aluCin,
    output logic                aluSrc,
    output decodePkg::extSelT   extSelect,
    output decodePkg::regDstT   regDst,
    output logic                jump,
    output logic                branch,
    output logic                memRead,
    output logic                memWrite,
    output logic                memToReg,
    output logic                regWrite,
    output logic                regToPc,
    output logic                pcToReg,
    output logic                halt,
    output logic                err,
    output logic                rFormat,
    output logic                iFormat
);
    import decodePkg::*;

    // Combinational decode results
    aluOpT  aluOpNext;
    extSelT extSelectNext;
    regDstT regDstNext;
    logic   aluInvANext, aluInvBNext, aluCinNext, aluSrcNext;
    logic   jumpNext, branchNext, memReadNext, memWriteNext, memToRegNext;
    logic   regWriteNext, regToPcNext, pcToRegNext, haltNext, errNext;
    logic   rFormatNext, iFormatNext;

    aluControl u_aluControl (.opcode, .funcMode, .aluOpNext, .aluInvANext, .aluInvBNext,
                             .aluCinNext, .aluSrcNext, .extSelectNext);

    flowControl u_flowControl (.opcode, .regDstNext, .jumpNext, .branchNext, .memReadNext,
                               .memWriteNext, .memToRegNext, .regWriteNext, .regToPcNext,
                               .pcToRegNext, .haltNext, .errNext, .rFormatNext,
                               .iFormatNext);

    // One-cycle decode/execute boundary
    controlStage u_controlStage (.*);

endmodule

// ==== dv/decode_props.sv ====
`timescale 1ns/1ns

module decodeProps (
    input logic                clk,
    input logic                rstN,
    input logic                instrValid,
    input decodePkg::aluOpT    aluOp,
    input logic                aluInvA,
    input logic                aluInvB,
    input logic                aluCin,
    input logic                aluSrc,
    input decodePkg::extSelT   extSelect,
    input decodePkg::regDstT   regDst,
    input logic                jump,
    input logic                branch,
    input logic                memRead,
    input logic                memWrite,
    input logic                memToReg,
    input logic                regWrite,
    input logic                regToPc,
    input logic                pcToReg,
    input logic                halt,
    input logic                err,
    input logic                rFormat,
    input logic                iFormat
);
    import decodePkg::*;

    ctrlWordT ctrlWord; // Whole registered word

    assign ctrlWord = {aluOp, aluInvA, aluInvB, aluCin, aluSrc, extSelect, regDst, jump,
                       branch, memRead, memWrite, memToReg, regWrite, regToPc, pcToReg,
                       halt, err, rFormat, iFormat};

    //////////////////////////////
    // Stage register rules
    //////////////////////////////
    bubbleIsZero: assert property (@(posedge clk) disable iff (!rstN)
        !$past(instrValid) |-> ctrlWord == '0)
        else $error("Control word not cleared after a bubble");

    errAlone: assert property (@(posedge clk) disable iff (!rstN)
        err |-> !(regWrite || memWrite || jump || branch))
        else $error("Illegal opcode carries side effects");

    jumpOrBranch: assert property (@(posedge clk) disable iff (!rstN)
        !(jump && branch))
        else $error("Jump and branch both set");

    loadWriteback: assert property (@(posedge clk) disable iff (!rstN)
        memRead |-> memToReg)                       // Loads always return memory data
        else $error("memRead without memToReg");

endmodule

// ==== dv/decodeTb.sv ====
`timescale 1ns/1ns

module decodeTb;
    import decodePkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int STEP_NS    = 7;  // Off the 50 ns edge grid
    localparam int EDGE_TRIES = 20; // About 1.4 clock periods per edge

    // One stimulus row with the expected control word
    typedef struct packed {
        logic     valid;
        opcodeT   op;
        funcModeT mode;
        aluOpT    aluOp;
        logic     invA, invB, cin, src;
        extSelT   ext;
        regDstT   regDst;
        logic     jump, branch, memRead, memWrite, memToReg, regWrite;
        logic     regToPc, pcToReg, halt, err, rFormat, iFormat;
    } rowT;

    logic     clk, rstN, instrValid;
    opcodeT   opcode;
    funcModeT funcMode;
    aluOpT    aluOp;
    extSelT   extSelect;
    regDstT   regDst;
    logic     aluInvA, aluInvB, aluCin, aluSrc;
    logic     jump, branch, memRead, memWrite, memToReg, regWrite;
    logic     regToPc, pcToReg, halt, err, rFormat, iFormat;

    rowT  rows[$];
    int   seed = 32'h657fe9dc;
    int   errorCount;
    logic edgeSeen;

    decodeTop u_decodeTop (.*);

    bind decodeTop decodeProps u_decodeProps (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    task automatic addBubble();
        rowT b;
        b = '0;                      // Expected word is all zero
        b.op   = $random(seed);
        b.mode = $random(seed);
        rows.push_back(b);
    endtask

    task automatic addRow(input opcodeT op, input funcModeT mode, input aluOpT alu,
                          input logic [3:0] aluBits, input extSelT ext,
                          input regDstT dst, input logic [11:0] flags);
        rowT r;
        r = '0;
        r.valid  = 1'b1;
        r.op     = op;
        r.mode   = mode;
        r.aluOp  = alu;
        r.ext    = ext;
        r.regDst = dst;
        {r.invA, r.invB, r.cin, r.src} = aluBits;
        {r.jump, r.branch, r.memRead, r.memWrite, r.memToReg, r.regWrite,
         r.regToPc, r.pcToReg, r.halt, r.err, r.rFormat, r.iFormat} = flags;
        rows.push_back(r);
        if (rows.size() % 5 == 4) addBubble();   // Bubble after every fourth instruction
    endtask

    task automatic buildTable();
        // aluBits  invA invB cin src
        // flags    jump branch memRd memWr | memToReg regWr regToPc pcToReg | halt err rFmt iFmt
        addRow(OP_HALT,  2'd0, 4'd0,       4'b0000, EXT_SIGN5,  REG_DST_RS,   12'b0000_0000_1000);
        addRow(OP_NOP,   2'd1, 4'd0,       4'b0000, EXT_SIGN5,  REG_DST_RS,   12'b0000_0000_0000);
        addRow(OP_SIIC,  2'd2, 4'd0,       4'b0000, EXT_SIGN5,  REG_DST_RS,   12'b0000_0000_0000);
        addRow(OP_RTI,   2'd3, 4'd0,       4'b0000, EXT_SIGN5,  REG_DST_RS,   12'b0000_0000_0000);
        // I-format 1
        addRow(OP_ADDI,  2'd0, ALU_ADD,    4'b0001, EXT_SIGN5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_SUBI,  2'd1, ALU_ADD,    4'b1011, EXT_SIGN5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_XORI,  2'd2, ALU_XOR,    4'b0001, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_ANDNI, 2'd3, ALU_AND,    4'b0101, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_ROLI,  2'd0, ALU_ROL,    4'b0001, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_SLLI,  2'd1, ALU_SLL,    4'b0001, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_RORI,  2'd2, ALU_ROR,    4'b0001, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        addRow(OP_SRLI,  2'd3, ALU_SRL,    4'b0001, EXT_ZERO5,  REG_DST_RD_I, 12'b0000_0100_0001);
        // Memory
        addRow(OP_ST,    2'd0, ALU_ADD,    4'b0001, EXT_SIGN5,  REG_DST_RS,   12'b0001_0000_0001);
        addRow(OP_LD,    2'd1, ALU_ADD,    4'b0001, EXT_SIGN5,  REG_DST_RD_I, 12'b0010_1100_0001);
        addRow(OP_STU,   2'd2, ALU_ADD,    4'b0001, EXT_SIGN5,  REG_DST_RS,   12'b0001_0100_0001);
        // R-format, one funcMode per row
        addRow(OP_ARITH, 2'd0, ALU_ADD,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_ARITH, 2'd1, ALU_ADD,    4'b1010, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_ARITH, 2'd2, ALU_XOR,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_ARITH, 2'd3, ALU_AND,    4'b0110, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SHIFT, 2'd0, ALU_ROL,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SHIFT, 2'd1, ALU_SLL,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SHIFT, 2'd2, ALU_ROR,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SHIFT, 2'd3, ALU_SRL,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_BTR,   2'd1, ALU_BTR,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SCO,   2'd2, ALU_SCO,    4'b0000, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SEQ,   2'd3, ALU_SEQ,    4'b0110, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SLT,   2'd0, ALU_SLT,    4'b0110, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        addRow(OP_SLE,   2'd1, ALU_SLE,    4'b0110, EXT_SIGN5,  REG_DST_RD_R, 12'b0000_0100_0010);
        // Branches and jumps
        addRow(OP_BEQZ,  2'd0, ALU_PASS_A, 4'b0000, EXT_SIGN8,  REG_DST_RS,   12'b0100_0000_0000);
        addRow(OP_BNEZ,  2'd1, ALU_PASS_A, 4'b0000, EXT_SIGN8,  REG_DST_RS,   12'b0100_0000_0000);
        addRow(OP_BLTZ,  2'd2, ALU_PASS_A, 4'b0000, EXT_SIGN8,  REG_DST_RS,   12'b0100_0000_0000);
        addRow(OP_BGEZ,  2'd3, ALU_PASS_A, 4'b0000, EXT_SIGN8,  REG_DST_RS,   12'b0100_0000_0000);
        addRow(OP_J,     2'd0, 4'd0,       4'b0000, EXT_SIGN11, REG_DST_RS,   12'b1000_0000_0000);
        addRow(OP_JR,    2'd1, ALU_ADD,    4'b0001, EXT_SIGN8,  REG_DST_RS,   12'b1000_0010_0000);
        addRow(OP_JAL,   2'd2, 4'd0,       4'b0000, EXT_SIGN11, REG_DST_R7,   12'b1000_0101_0000);
        addRow(OP_JALR,  2'd3, ALU_ADD,    4'b0001, EXT_SIGN8,  REG_DST_R7,   12'b1000_0111_0000);
        // Immediate loads
        addRow(OP_LBI,   2'd0, ALU_PASS_B, 4'b0001, EXT_SIGN8,  REG_DST_RS,   12'b0000_0100_0000);
        addRow(OP_SLBI,  2'd1, ALU_SLBI,   4'b0001, EXT_ZERO8,  REG_DST_RS,   12'b0000_0100_0000);
        // Back-to-back bubbles at the tail
        for (int k = 0; k < 4; k++) addBubble();
    endtask

    //////////////////////////////
    // Waits and checks
    //////////////////////////////
    task automatic waitClock(input logic rising);
        int tries;
        tries    = 0;
        edgeSeen = 1'b0;
        while (!edgeSeen && tries < EDGE_TRIES) begin
            fork
                begin
                    if (rising) @(posedge clk);
                    else @(negedge clk);
                    edgeSeen = 1'b1;
                end
                #(STEP_NS);
            join_any
            disable fork;
            tries++;
        end
        if (!edgeSeen) begin
            $display("TIMEOUT at %0t: clock edge did not arrive within %0d ns",
                     $time, STEP_NS * EDGE_TRIES);
            errorCount++;
            $display("Decode test ended with %0d errors", errorCount);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic checkField(input int rowIdx, input string field,
                              input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: row %0d field %s got %0h expected %0h",
                     $time, rowIdx, field, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkRow(input int rowIdx, input rowT r);
        checkField(rowIdx, "aluOp",     aluOp,     r.aluOp);
        checkField(rowIdx, "aluInvA",   aluInvA,   r.invA);
        checkField(rowIdx, "aluInvB",   aluInvB,   r.invB);
        checkField(rowIdx, "aluCin",    aluCin,    r.cin);
        checkField(rowIdx, "aluSrc",    aluSrc,    r.src);
        checkField(rowIdx, "extSelect", extSelect, r.ext);
        checkField(rowIdx, "regDst",    regDst,    r.regDst);
        checkField(rowIdx, "jump",      jump,      r.jump);
        checkField(rowIdx, "branch",    branch,    r.branch);
        checkField(rowIdx, "memRead",   memRead,   r.memRead);
        checkField(rowIdx, "memWrite",  memWrite,  r.memWrite);
        checkField(rowIdx, "memToReg",  memToReg,  r.memToReg);
        checkField(rowIdx, "regWrite",  regWrite,  r.regWrite);
        checkField(rowIdx, "regToPc",   regToPc,   r.regToPc);
        checkField(rowIdx, "pcToReg",   pcToReg,   r.pcToReg);
        checkField(rowIdx, "halt",      halt,      r.halt);
        checkField(rowIdx, "err",       err,       r.err);
        checkField(rowIdx, "rFormat",   rFormat,   r.rFormat);
        checkField(rowIdx, "iFormat",   iFormat,   r.iFormat);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rowT zeroRow;
        zeroRow    = '0;
        errorCount = 0;
        rstN       = 1'b0;
        instrValid = 1'b1;           // Valid JALR held during reset
        opcode     = OP_JALR;
        funcMode   = 2'd3;
        buildTable();

        // Word stays zero through reset despite the live JALR, row -1 in reports
        for (int c = 0; c < 5; c++) begin
            waitClock(1'b1);
            waitClock(1'b0);
            checkRow(-1, zeroRow);
        end
        waitClock(1'b1);
        rstN       <= 1'b1;
        instrValid <= 1'b0;

        // Row i driven at edge i, captured at edge i+1, checked at the falling edge after
        for (int i = 0; i <= rows.size(); i++) begin
            waitClock(1'b1);
            if (i < rows.size()) begin
                instrValid <= rows[i].valid;
                opcode     <= rows[i].op;
                funcMode   <= rows[i].mode;
            end else begin
                instrValid <= 1'b0;          // Drain
            end
            waitClock(1'b0);
            if (i > 0) checkRow(i - 1, rows[i - 1]);
        end

        $display("Decode test ended with %0d errors over %0d rows", errorCount, rows.size());
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/decodePkg.sv
design/aluControl.sv
design/flowControl.sv
design/controlStage.sv
design/decodeTop.sv
dv/decode_props.sv
dv/decodeTb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - design/decodePkg.sv
  - design/aluControl.sv
  - design/flowControl.sv
  - design/controlStage.sv
  - design/decodeTop.sv
  - target: test
    files:
      - dv/decode_props.sv
      - dv/decodeTb.sv
